// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [3:0]  be_t;    // One bit per byte lane
    typedef logic [1:0]  lane_t;

    // MIPS primary opcodes, instr[31:26]
    localparam opcode_t OPCODE_LB  = 6'h20;
    localparam opcode_t OPCODE_LH  = 6'h21;
    localparam opcode_t OPCODE_LWL = 6'h22;
    localparam opcode_t OPCODE_LW  = 6'h23;
    localparam opcode_t OPCODE_LBU = 6'h24;
    localparam opcode_t OPCODE_LHU = 6'h25;
    localparam opcode_t OPCODE_LWR = 6'h26;
    localparam opcode_t OPCODE_SB  = 6'h28;
    localparam opcode_t OPCODE_SH  = 6'h29;
    localparam opcode_t OPCODE_SW  = 6'h2b;

    typedef enum logic [3:0] {
        op_none,    // Bubble or non-memory opcode
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwl,
        op_lwr,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

endpackage

`default_nettype wire

// ==== hdl/lsu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    input  lsu_pkg::word_t   instr,
    input  lsu_pkg::word_t   rs_val,
    input  lsu_pkg::word_t   rt_val,
    output lsu_pkg::mem_op_e op,
    output lsu_pkg::word_t   base,
    output lsu_pkg::word_t   offset,
    output lsu_pkg::word_t   rt
);

    lsu_pkg::opcode_t opcode;
    lsu_pkg::mem_op_e op_dec;
    lsu_pkg::word_t   imm_ext;

    assign opcode  = instr[31:26];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};    // Signed 16-bit offset

    always_comb begin
        case (opcode)
            lsu_pkg::OPCODE_LB:  op_dec = lsu_pkg::op_lb;
            lsu_pkg::OPCODE_LBU: op_dec = lsu_pkg::op_lbu;
            lsu_pkg::OPCODE_LH:  op_dec = lsu_pkg::op_lh;
            lsu_pkg::OPCODE_LHU: op_dec = lsu_pkg::op_lhu;
            lsu_pkg::OPCODE_LW:  op_dec = lsu_pkg::op_lw;
            lsu_pkg::OPCODE_LWL: op_dec = lsu_pkg::op_lwl;
            lsu_pkg::OPCODE_LWR: op_dec = lsu_pkg::op_lwr;
            lsu_pkg::OPCODE_SB:  op_dec = lsu_pkg::op_sb;
            lsu_pkg::OPCODE_SH:  op_dec = lsu_pkg::op_sh;
            lsu_pkg::OPCODE_SW:  op_dec = lsu_pkg::op_sw;
            default:             op_dec = lsu_pkg::op_none;    // Not a memory op
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op <= lsu_pkg::op_none;
        end else begin
            op <= instr_valid ? op_dec : lsu_pkg::op_none;    // Bubble when idle
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            base   <= rs_val;
            offset <= imm_ext;
            rt     <= rt_val;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_agen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_agen #(
    parameter int MEM_WORDS = 256
) (
    input  lsu_pkg::mem_op_e             op,
    input  lsu_pkg::word_t               base,
    input  lsu_pkg::word_t               offset,
    output logic [$clog2(MEM_WORDS)-1:0] word_index,
    output lsu_pkg::lane_t               lane,
    output logic                         misaligned
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    lsu_pkg::word_t eff_addr;

    assign eff_addr   = base + offset;
    assign lane       = eff_addr[1:0];
    assign word_index = eff_addr[IDX_W+1:2];    // Wraps at RAM depth

    // Halfwords need an even lane, words lane 0
    always_comb begin
        case (op)
            lsu_pkg::op_lh,
            lsu_pkg::op_lhu,
            lsu_pkg::op_sh: begin
                misaligned = lane[0];
            end
            lsu_pkg::op_lw,
            lsu_pkg::op_sw: begin
                misaligned = (lane != 2'd0);
            end
            default: begin
                misaligned = 1'b0;    // Bytes, LWL, LWR, bubbles
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/byte_lane_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ctrl (
    input  lsu_pkg::mem_op_e op,
    input  lsu_pkg::lane_t   lane,
    input  lsu_pkg::word_t   rt,
    input  logic             misaligned,
    output lsu_pkg::be_t     byteenable,
    output lsu_pkg::word_t   write_data,
    output logic             is_load
);

    logic [7:0]  rt_byte;
    logic [15:0] rt_half;
    lsu_pkg::be_t store_be;

    assign rt_byte = rt[7:0];
    assign rt_half = rt[15:0];

    // Store lane steering
    always_comb begin
        store_be   = 4'b0000;
        write_data = rt;
        case (op)
            lsu_pkg::op_sb: begin
                write_data = {4{rt_byte}};    // Byte on every lane, mask picks one
                case (lane)
                    2'd0: store_be = 4'b0001;
                    2'd1: store_be = 4'b0010;
                    2'd2: store_be = 4'b0100;
                    2'd3: store_be = 4'b1000;
                    default: store_be = 4'b0000;
                endcase
            end
            lsu_pkg::op_sh: begin
                write_data = {2{rt_half}};
                case (lane)
                    2'd0: store_be = 4'b0011;
                    2'd2: store_be = 4'b1100;
                    default: store_be = 4'b0000;    // Odd lane faults anyway
                endcase
            end
            lsu_pkg::op_sw: begin
                store_be = 4'b1111;
            end
            default: begin
                store_be = 4'b0000;    // Loads and bubbles write nothing
            end
        endcase
    end

    assign byteenable = misaligned ? 4'b0000 : store_be;    // Refused store

    always_comb begin
        case (op)
            lsu_pkg::op_lb,
            lsu_pkg::op_lbu,
            lsu_pkg::op_lh,
            lsu_pkg::op_lhu,
            lsu_pkg::op_lw,
            lsu_pkg::op_lwl,
            lsu_pkg::op_lwr: begin
                is_load = 1'b1;
            end
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [$clog2(MEM_WORDS)-1:0] word_index,
    input  lsu_pkg::be_t                 byteenable,
    input  lsu_pkg::word_t               write_data,
    output lsu_pkg::word_t               read_data
);

    lsu_pkg::word_t mem [MEM_WORDS];
    lsu_pkg::word_t cur_word;
    lsu_pkg::word_t next_word;

    assign cur_word = mem[word_index];

    // Merge enabled lanes over the stored word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            next_word[8*b +: 8] = byteenable[b] ? write_data[8*b +: 8] : cur_word[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (byteenable != 4'b0000) begin
            mem[word_index] <= next_word;
        end
        read_data <= next_word;    // Write-first read
    end

endmodule

`default_nettype wire

// ==== hdl/load_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_merge (
    input  logic             clk,
    input  logic             rst,
    input  lsu_pkg::mem_op_e op,
    input  lsu_pkg::lane_t   lane,
    input  lsu_pkg::word_t   rt,
    input  logic             misaligned,
    input  lsu_pkg::word_t   read_data,
    output logic             load_valid,
    output lsu_pkg::word_t   load_data,
    output logic             addr_fault
);

    lsu_pkg::mem_op_e op_q;
    lsu_pkg::lane_t   lane_q;
    lsu_pkg::word_t   rt_q;
    logic             mis_q;
    logic [7:0]       sel_byte;
    logic [15:0]      sel_half;
    lsu_pkg::word_t   result;
    logic             is_load_q;

    // Stage-2 registers, aligned with the RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            op_q  <= lsu_pkg::op_none;
            mis_q <= 1'b0;
        end else begin
            op_q  <= op;
            mis_q <= misaligned;
        end
    end

    always_ff @(posedge clk) begin
        lane_q <= lane;
        rt_q   <= rt;
    end

    assign sel_byte = read_data[8*lane_q +: 8];
    assign sel_half = lane_q[1] ? read_data[31:16] : read_data[15:0];

    always_comb begin
        is_load_q = 1'b1;
        case (op_q)
            lsu_pkg::op_lb:  result = {{24{sel_byte[7]}}, sel_byte};
            lsu_pkg::op_lbu: result = {24'h000000, sel_byte};
            lsu_pkg::op_lh:  result = {{16{sel_half[15]}}, sel_half};    // Both halves
            lsu_pkg::op_lhu: result = {16'h0000, sel_half};
            lsu_pkg::op_lw:  result = read_data;
            lsu_pkg::op_lwl: begin
                case (lane_q)    // High rt bytes kept above memory bytes
                    2'd0: result = read_data;
                    2'd1: result = {rt_q[31:24], read_data[31:8]};
                    2'd2: result = {rt_q[31:16], read_data[31:16]};
                    default: result = {rt_q[31:8], read_data[31:24]};
                endcase
            end
            lsu_pkg::op_lwr: begin
                case (lane_q)    // Low rt bytes kept below memory bytes
                    2'd0: result = {read_data[7:0], rt_q[23:0]};
                    2'd1: result = {read_data[15:0], rt_q[15:0]};
                    2'd2: result = {read_data[23:0], rt_q[7:0]};
                    default: result = read_data;
                endcase
            end
            default: begin
                result    = 32'h0000_0000;
                is_load_q = 1'b0;    // Stores and bubbles
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
            addr_fault <= 1'b0;
        end else begin
            load_valid <= is_load_q && !mis_q;
            addr_fault <= mis_q;
        end
    end

    always_ff @(posedge clk) begin
        load_data <= result;
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid,
    input  lsu_pkg::word_t instr,
    input  lsu_pkg::word_t rs_val,
    input  lsu_pkg::word_t rt_val,
    output logic           load_valid,
    output lsu_pkg::word_t load_data,
    output logic           addr_fault
);

    // Stage 1
    lsu_pkg::mem_op_e             s1_op;
    lsu_pkg::word_t               s1_base;
    lsu_pkg::word_t               s1_offset;
    lsu_pkg::word_t               s1_rt;
    logic [$clog2(MEM_WORDS)-1:0] s1_word_index;
    lsu_pkg::lane_t               s1_lane;
    logic                         s1_misaligned;
    lsu_pkg::be_t                 s1_byteenable;
    lsu_pkg::word_t               s1_write_data;

    // Stage 2
    lsu_pkg::word_t               s2_read_data;

    lsu_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .instr_valid(instr_valid),
        .instr      (instr),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .op         (s1_op),
        .base       (s1_base),
        .offset     (s1_offset),
        .rt         (s1_rt)
    );

    lsu_agen #(
        .MEM_WORDS(MEM_WORDS)
    ) u_agen (
        .op        (s1_op),
        .base      (s1_base),
        .offset    (s1_offset),
        .word_index(s1_word_index),
        .lane      (s1_lane),
        .misaligned(s1_misaligned)
    );

    byte_lane_ctrl u_lanes (
        .op        (s1_op),
        .lane      (s1_lane),
        .rt        (s1_rt),
        .misaligned(s1_misaligned),
        .byteenable(s1_byteenable),
        .write_data(s1_write_data),
        .is_load   ()
    );

    data_ram #(
        .MEM_WORDS(MEM_WORDS)
    ) u_ram (
        .clk       (clk),
        .word_index(s1_word_index),
        .byteenable(s1_byteenable),
        .write_data(s1_write_data),
        .read_data (s2_read_data)
    );

    load_merge u_merge (
        .clk       (clk),
        .rst       (rst),
        .op        (s1_op),
        .lane      (s1_lane),
        .rt        (s1_rt),
        .misaligned(s1_misaligned),
        .read_data (s2_read_data),
        .load_valid(load_valid),
        .load_data (load_data),
        .addr_fault(addr_fault)
    );

endmodule

`default_nettype wire

// ==== bench/lsu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_sva (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic load_valid,
    input logic addr_fault
);

    a_one_pulse: assert property (@(posedge clk) disable iff (rst)
        !(load_valid && addr_fault))
        else $error("load_valid and addr_fault high in the same cycle");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !load_valid && !addr_fault)
        else $error("result pulse right after a reset cycle");

    // Fixed latency from sampled strobe to result
    a_latency: assert property (@(posedge clk) disable iff (rst)
        (load_valid || addr_fault) |-> $past(instr_valid, 3))
        else $error("result pulse without an instruction three cycles earlier");

endmodule

bind lsu_top lsu_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .load_valid (load_valid),
    .addr_fault (addr_fault)
);

`default_nettype wire

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int MEM_WORDS    = 256;
    localparam int MEM_BYTES    = 4 * MEM_WORDS;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_COUNT   = 300;
    // Directed phases stay under 2*MEM_WORDS + 100 cycles, random steps under 3 each
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 * MEM_WORDS + 100 + 3 * RAND_COUNT + 50;

    logic           clk;
    logic           rst;
    logic           instr_valid;
    lsu_pkg::word_t instr;
    lsu_pkg::word_t rs_val;
    lsu_pkg::word_t rt_val;
    logic           load_valid;
    lsu_pkg::word_t load_data;
    logic           addr_fault;

    logic [7:0]     shadow [MEM_BYTES];    // Byte-wide memory model
    logic [64:0]    exp_q [$];             // {due edge, fault, data}, oldest first
    int             edge_count = 0;
    int             error_count = 0;
    int             check_count = 0;
    integer         seed;

    lsu_top #(
        .MEM_WORDS(MEM_WORDS)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .instr_valid(instr_valid),
        .instr      (instr),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .load_valid (load_valid),
        .load_data  (load_data),
        .addr_fault (addr_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) edge_count <= edge_count + 1;

    // Expected load word from the memory model, or a fault
    function automatic lsu_pkg::word_t expect_result(input lsu_pkg::opcode_t opc,
            input lsu_pkg::word_t addr, input lsu_pkg::word_t rt,
            output logic has_pulse, output logic fault);
        int             ln;
        int             wa;
        lsu_pkg::word_t mem;
        lsu_pkg::word_t res;
        ln        = addr[1:0];
        wa        = int'(addr % MEM_BYTES) - ln;
        has_pulse = 1'b1;
        fault     = 1'b0;
        res       = rt;
        for (int b = 0; b < 4; b++) begin
            mem[8*b +: 8] = shadow[wa + b];
        end
        case (opc)
            lsu_pkg::OPCODE_LB:  res = {{24{mem[8*ln+7]}}, mem[8*ln +: 8]};
            lsu_pkg::OPCODE_LBU: res = {24'h000000, mem[8*ln +: 8]};
            lsu_pkg::OPCODE_LH,
            lsu_pkg::OPCODE_LHU: begin
                fault = ln[0];
                if (!fault) begin
                    res = {16'h0000, mem[8*ln +: 16]};
                    if (opc == lsu_pkg::OPCODE_LH) res[31:16] = {16{mem[8*ln+15]}};
                end
            end
            lsu_pkg::OPCODE_LW: begin
                fault = (ln != 0);
                res   = mem;
            end
            lsu_pkg::OPCODE_LWL: begin    // Bytes from the lane upward fill the low end
                for (int j = 0; j < 4 - ln; j++) begin
                    res[8*j +: 8] = mem[8*(ln+j) +: 8];
                end
            end
            lsu_pkg::OPCODE_LWR: begin    // Bytes up to the lane fill the high end
                for (int j = 3 - ln; j < 4; j++) begin
                    res[8*j +: 8] = mem[8*(j+ln-3) +: 8];
                end
            end
            lsu_pkg::OPCODE_SH: begin
                fault     = ln[0];
                has_pulse = fault;
            end
            lsu_pkg::OPCODE_SW: begin
                fault     = (ln != 0);
                has_pulse = fault;
            end
            default: has_pulse = 1'b0;    // SB and non-memory opcodes
        endcase
        return res;
    endfunction

    task automatic apply_store(input lsu_pkg::opcode_t opc, input lsu_pkg::word_t addr,
            input lsu_pkg::word_t rt);
        int a;
        int n;
        a = int'(addr % MEM_BYTES);
        n = 0;
        if (opc == lsu_pkg::OPCODE_SB) n = 1;
        if (opc == lsu_pkg::OPCODE_SH && a % 2 == 0) n = 2;
        if (opc == lsu_pkg::OPCODE_SW && a % 4 == 0) n = 4;
        for (int b = 0; b < n; b++) begin
            shadow[a + b] = rt[8*b +: 8];
        end
    endtask

    task automatic issue(input lsu_pkg::opcode_t opc, input lsu_pkg::word_t rs,
            input logic [15:0] imm, input lsu_pkg::word_t rt);
        lsu_pkg::word_t addr;
        lsu_pkg::word_t exp;
        logic           has_pulse;
        logic           fault;
        addr = rs + {{16{imm[15]}}, imm};
        exp  = expect_result(opc, addr, rt, has_pulse, fault);
        apply_store(opc, addr, rt);
        @(posedge clk);
        if (has_pulse) exp_q.push_back({32'(edge_count + 4), fault, exp});    // Seen 4 edges on
        instr_valid <= 1'b1;
        instr       <= {opc, 5'd4, 5'd5, imm};
        rs_val      <= rs;
        rt_val      <= rt;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic compare_word(input logic [31:0] expected, input logic [31:0] actual,
            input string what);
        check_count++;
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // First seven entries are loads
    function automatic lsu_pkg::opcode_t pick_opcode(input int sel);
        case (sel)
            0:       return lsu_pkg::OPCODE_LB;
            1:       return lsu_pkg::OPCODE_LBU;
            2:       return lsu_pkg::OPCODE_LH;
            3:       return lsu_pkg::OPCODE_LHU;
            4:       return lsu_pkg::OPCODE_LW;
            5:       return lsu_pkg::OPCODE_LWL;
            6:       return lsu_pkg::OPCODE_LWR;
            7:       return lsu_pkg::OPCODE_SB;
            8:       return lsu_pkg::OPCODE_SH;
            9:       return lsu_pkg::OPCODE_SW;
            10:      return 6'h00;    // SPECIAL, no memory access
            default: return 6'h0f;    // LUI
        endcase
    endfunction

    always @(negedge clk) begin
        logic [64:0] head;
        if (!rst && (load_valid || addr_fault)) begin
            if (exp_q.size() == 0) begin
                $display("result pulse at %0t ns with no load or fault outstanding", $time);
                error_count++;
            end else begin
                head = exp_q.pop_front();
                compare_word(head[64:33], edge_count, "pulse edge");
                compare_word(head[32], addr_fault, "addr_fault");
                compare_word(!head[32], load_valid, "load_valid");
                if (!head[32]) compare_word(head[31:0], load_data, "load_data");
            end
        end else if (exp_q.size() != 0 && int'(exp_q[0][64:33]) <= edge_count) begin
            $display("no result pulse at %0t ns for an instruction due at this edge", $time);
            error_count++;
            void'(exp_q.pop_front());
        end
    end

    initial begin
        int               w;
        int               ln;
        int               i;
        int               tgt;
        lsu_pkg::opcode_t opc;
        logic [15:0]      imm;
        seed        = 50;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rs_val      = '0;
        rt_val      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // Fill every word, read back through address forms that wrap
        for (w = 0; w < MEM_WORDS; w++) begin
            issue(lsu_pkg::OPCODE_SW, 4 * w, 16'h0, (w + 1) * 32'h9e37_79b9 ^ (w << 20));
        end
        for (w = 0; w < MEM_WORDS; w++) begin
            if (w % 2 == 0) issue(lsu_pkg::OPCODE_LW, 4 * w + 32'h1000, 16'hf000, '0);
            else issue(lsu_pkg::OPCODE_LW, 4 * w + 32'h0004_0000, 16'h0, '0);
        end
        for (ln = 0; ln < 4; ln++) begin
            issue(lsu_pkg::OPCODE_SB, 32'h40 + 4 * ln, 16'(ln), $random(seed));
            issue(lsu_pkg::OPCODE_LW, 32'h40 + 4 * ln, 16'h0, '0);
        end
        for (ln = 0; ln < 4; ln += 2) begin
            issue(lsu_pkg::OPCODE_SH, 32'h60 + 4 * ln, 16'(ln), $random(seed));
            issue(lsu_pkg::OPCODE_LW, 32'h60 + 4 * ln, 16'h0, '0);
        end
        // Bytes and halves with the top bit set and clear
        issue(lsu_pkg::OPCODE_SW, 32'h80, 16'h0, 32'h7f80_80ff);
        issue(lsu_pkg::OPCODE_SW, 32'h84, 16'h0, 32'h807f_01fe);
        for (i = 0; i < 8; i++) begin
            issue(lsu_pkg::OPCODE_LB, 32'h80, 16'(i), '0);
            issue(lsu_pkg::OPCODE_LBU, 32'h80, 16'(i), '0);
            if (i % 2 == 0) begin
                issue(lsu_pkg::OPCODE_LH, 32'h80, 16'(i), '0);
                issue(lsu_pkg::OPCODE_LHU, 32'h80, 16'(i), '0);
            end
        end
        for (ln = 0; ln < 4; ln++) begin
            issue(lsu_pkg::OPCODE_LWL, 32'ha0, 16'(ln), $random(seed));
            issue(lsu_pkg::OPCODE_LWR, 32'ha0, 16'(ln), $random(seed));
        end
        // Misaligned accesses, word read back after each lane
        for (ln = 1; ln < 4; ln++) begin
            issue(lsu_pkg::OPCODE_LW, 32'hc0, 16'(ln), '0);
            issue(lsu_pkg::OPCODE_SW, 32'hc0, 16'(ln), $random(seed));
            if (ln != 2) begin
                issue(lsu_pkg::OPCODE_LH, 32'hc0, 16'(ln), '0);
                issue(lsu_pkg::OPCODE_LHU, 32'hc0, 16'(ln), '0);
                issue(lsu_pkg::OPCODE_SH, 32'hc0, 16'(ln), $random(seed));
            end
            issue(lsu_pkg::OPCODE_LW, 32'hc0, 16'h0, '0);
        end
        for (i = 0; i < RAND_COUNT; i++) begin
            opc = pick_opcode({$random(seed)} % 12);
            tgt = 32'he0 + {$random(seed)} % 32;    // Small window, frequent hits
            imm = $random(seed);
            issue(opc, tgt - {{16{imm[15]}}, imm} + ($random(seed) << 10), imm, $random(seed));
            if ((opc == lsu_pkg::OPCODE_SB || opc == lsu_pkg::OPCODE_SH
                    || opc == lsu_pkg::OPCODE_SW) && {$random(seed)} % 2 == 0) begin
                issue(pick_opcode({$random(seed)} % 7), tgt - tgt % 4,
                      16'({$random(seed)} % 4), $random(seed));    // Same word, next cycle
            end
            if ({$random(seed)} % 4 == 0) idle(1);
        end
        idle(1);
        while (exp_q.size() != 0) @(posedge clk);
        idle(4);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) $display("*** TEST PASSED ***");
        else $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", RUN_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_agen.sv
hdl/byte_lane_ctrl.sv
hdl/data_ram.sv
hdl/load_merge.sv
hdl/lsu_top.sv
bench/lsu_sva.sv
bench/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_decode.sv
      - hdl/lsu_agen.sv
      - hdl/byte_lane_ctrl.sv
      - hdl/data_ram.sv
      - hdl/load_merge.sv
      - hdl/lsu_top.sv
  - target: test
    files:
      - bench/lsu_sva.sv
      - bench/lsu_tb.sv
